//--- common/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 4;
    localparam int immWidth = 16;

    // Operation groups, top two bits of the word
    localparam logic [1:0] movAluImm = 2'b00;
    localparam logic [1:0] aluReg = 2'b01;
    localparam logic [1:0] memOp = 2'b10;
    localparam logic [1:0] branch = 2'b11;

    localparam logic [3:0] opAdd = 4'b0001;
    localparam logic [3:0] opSub = 4'b0010;
    localparam logic [3:0] opAnd = 4'b0011;
    localparam logic [3:0] opAdds = 4'b1001; // Flag-setting forms
    localparam logic [3:0] opSubs = 4'b1010;
    localparam logic [3:0] opAnds = 4'b1011;

    // Branch conditions share the secondLevel field
    localparam logic [3:0] condEq = 4'b0000;
    localparam logic [3:0] condNe = 4'b0001;
    localparam logic [3:0] condMi = 4'b0100;

    // Move group, low three bits of secondLevel
    localparam logic [2:0] movMov = 3'd0;
    localparam logic [2:0] movMovt = 3'd1;
    localparam logic [2:0] movClr = 3'd2;
    localparam logic [2:0] movSet = 3'd3;
    localparam logic [2:0] movLsl = 3'd4;
    localparam logic [2:0] movLsr = 3'd5;
    localparam logic [2:0] movMovf = 3'd6;

    // Memory group with neither store nor load, used while halted
    localparam logic [3:0] memIdle = 4'b0010;

    typedef union packed {
        struct packed {
            logic [1:0] firstLevelDecode;
            logic specialEncoding;
            logic [3:0] secondLevelDecode;
            logic [regAddrWidth-1:0] destReg;
            logic [regAddrWidth-1:0] sourceFirstReg;
            logic [immWidth-1:0] imm;
            logic spare;
        } immForm;
        struct packed {
            logic [1:0] firstLevelDecode;
            logic specialEncoding;
            logic [3:0] secondLevelDecode;
            logic [regAddrWidth-1:0] destReg;
            logic [regAddrWidth-1:0] sourceFirstReg;
            logic [regAddrWidth-1:0] sourceSecReg;
            logic [12:0] unused;
        } regForm;
    } instrWord;

endpackage

//--- logic/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
    parameter int progDepth = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic progWrite,
    input  logic [$clog2(progDepth)-1:0] progAddr,
    input  logic [cpuPkg::dataWidth-1:0] progData,
    input  logic exeOverride,
    input  logic [cpuPkg::immWidth-1:0] exeData,
    output logic [cpuPkg::dataWidth-1:0] pc,
    output cpuPkg::instrWord instr
);

    localparam int addrBits = $clog2(progDepth);

    cpuPkg::instrWord progMem [progDepth];
    logic [cpuPkg::dataWidth-1:0] branchOffset;

    // Relative branch distance in words
    assign branchOffset = {{(cpuPkg::dataWidth-cpuPkg::immWidth){exeData[cpuPkg::immWidth-1]}},
                           exeData};

    always_ff @(posedge clk) begin
        if (progWrite && !run) begin
            progMem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0; // Held at the first word while loading
        end else if (exeOverride) begin
            pc <= pc + branchOffset;
        end else begin
            pc <= pc + 1'b1;
        end
    end

    // All-zero word while halted
    assign instr = run ? progMem[pc[addrBits-1:0]] : '0;

endmodule

//--- logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic run,
    input  cpuPkg::instrWord instr,
    output logic [1:0] firstLevelDecode,
    output logic specialEncoding,
    output logic [3:0] secondLevelDecode,
    output logic [2:0] aluFunctions,
    output logic [cpuPkg::regAddrWidth-1:0] destReg,
    output logic [cpuPkg::regAddrWidth-1:0] sourceFirstReg,
    output logic [cpuPkg::regAddrWidth-1:0] sourceSecReg,
    output logic [cpuPkg::immWidth-1:0] imm
);

    always_comb begin
        firstLevelDecode = instr.immForm.firstLevelDecode;
        specialEncoding = instr.immForm.specialEncoding;
        secondLevelDecode = instr.immForm.secondLevelDecode;
        destReg = instr.immForm.destReg;
        sourceFirstReg = instr.immForm.sourceFirstReg;
        sourceSecReg = '0;
        imm = '0;

        if (!run) begin
            // Halted, so report a memory slot that neither stores nor loads
            firstLevelDecode = cpuPkg::memOp;
            specialEncoding = 1'b0;
            secondLevelDecode = cpuPkg::memIdle;
            destReg = '0;
            sourceFirstReg = '0;
        end else if (instr.immForm.firstLevelDecode == cpuPkg::aluReg) begin
            sourceSecReg = instr.regForm.sourceSecReg; // Register view
        end else begin
            imm = instr.immForm.imm; // Immediate view
        end
    end

    // Move function and store bit live in the low bits
    assign aluFunctions = secondLevelDecode[2:0];

endmodule

//--- execute/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic clk,
    input  logic rst,
    input  logic [1:0] firstLevelDecode,
    input  logic specialEncoding,
    input  logic [3:0] secondLevelDecode,
    input  logic [2:0] aluFunctions,
    input  logic [cpuPkg::immWidth-1:0] imm,
    input  logic [cpuPkg::regAddrWidth-1:0] destReg,
    input  logic [cpuPkg::regAddrWidth-1:0] sourceFirstReg,
    input  logic [cpuPkg::regAddrWidth-1:0] sourceSecReg,
    input  logic [cpuPkg::dataWidth-1:0] readDataDest,
    input  logic [cpuPkg::dataWidth-1:0] readDataFirst,
    input  logic [cpuPkg::dataWidth-1:0] readDataSec,
    output logic [cpuPkg::regAddrWidth-1:0] readRegDest,
    output logic [cpuPkg::regAddrWidth-1:0] readRegFirst,
    output logic [cpuPkg::regAddrWidth-1:0] readRegSec,
    output logic [cpuPkg::dataWidth-1:0] writeData,
    output logic writeToReg,
    output logic exeOverride,
    output logic [cpuPkg::immWidth-1:0] exeData,
    output logic [cpuPkg::dataWidth-1:0] memoryDataOut,
    output logic [cpuPkg::dataWidth-1:0] memoryAddressOut,
    output logic memoryWrite,
    output logic memoryRead,
    input  logic [cpuPkg::dataWidth-1:0] memoryDataIn
);

    localparam int msb = cpuPkg::dataWidth - 1;

    logic [3:0] flags; // NZCV
    logic [3:0] flagsNext;
    logic [msb:0] immExt;
    logic [msb:0] operandB;
    logic [msb+1:0] sum;
    logic [msb+1:0] diff;
    logic [msb:0] andResult;
    logic isAluGroup;

    assign exeData = imm;
    assign immExt = {{(cpuPkg::dataWidth-cpuPkg::immWidth){imm[cpuPkg::immWidth-1]}}, imm};

    // Second operand is a register only in the register group
    assign operandB = (firstLevelDecode == cpuPkg::aluReg) ? readDataSec : immExt;
    assign sum = {1'b0, readDataFirst} + {1'b0, operandB};
    assign diff = {1'b0, readDataFirst} - {1'b0, operandB};
    assign andResult = readDataFirst & operandB;

    assign isAluGroup = (firstLevelDecode == cpuPkg::aluReg) ||
                        (firstLevelDecode == cpuPkg::movAluImm && specialEncoding);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= 4'b0000;
        end else begin
            flags <= flagsNext;
        end
    end

    always_comb begin
        exeOverride = 1'b0;
        readRegDest = destReg;
        readRegFirst = '0;
        readRegSec = '0;
        writeToReg = 1'b0;
        writeData = '0;
        memoryWrite = 1'b0;
        memoryRead = 1'b0;
        memoryDataOut = '0;
        memoryAddressOut = '0;
        flagsNext = flags;

        case (firstLevelDecode)
            cpuPkg::branch: begin
                case (secondLevelDecode)
                    cpuPkg::condEq: exeOverride = flags[2];
                    cpuPkg::condNe: exeOverride = !flags[2];
                    cpuPkg::condMi: exeOverride = flags[3];
                    default: exeOverride = 1'b0;
                endcase
            end

            cpuPkg::memOp: begin
                readRegFirst = sourceFirstReg; // Base register
                memoryAddressOut = readDataFirst + immExt;
                if (aluFunctions[0]) begin
                    memoryDataOut = readDataDest;
                    memoryWrite = 1'b1;
                end else if (!aluFunctions[1]) begin
                    // Load returns through the same cycle
                    memoryRead = 1'b1;
                    writeData = memoryDataIn;
                    writeToReg = 1'b1;
                end
            end

            cpuPkg::movAluImm: begin
                if (!specialEncoding) begin
                    readRegFirst = sourceFirstReg;
                    writeToReg = 1'b1;
                    case (aluFunctions)
                        cpuPkg::movMov: writeData = immExt;
                        cpuPkg::movMovt: writeData = {imm, readDataDest[15:0]};
                        cpuPkg::movClr: writeData = '0;
                        cpuPkg::movSet: writeData = '1;
                        cpuPkg::movLsl: writeData = readDataFirst << imm;
                        cpuPkg::movLsr: writeData = readDataFirst >> imm;
                        cpuPkg::movMovf: writeData = {readDataDest[msb:4], flags};
                        default: writeToReg = 1'b0;
                    endcase
                end
            end

            default: ;
        endcase

        if (isAluGroup) begin
            readRegFirst = sourceFirstReg;
            readRegSec = sourceSecReg; // Zero in the immediate form
            writeToReg = 1'b1;
            case (secondLevelDecode)
                cpuPkg::opAdd: writeData = sum[msb:0];
                cpuPkg::opSub: writeData = diff[msb:0];
                cpuPkg::opAnd: writeData = andResult;
                cpuPkg::opAdds: begin
                    writeData = sum[msb:0];
                    flagsNext[3] = sum[msb];
                    flagsNext[2] = (sum[msb:0] == '0);
                    flagsNext[1] = sum[msb+1];
                    flagsNext[0] = !(readDataFirst[msb] ^ operandB[msb]) &&
                                   (readDataFirst[msb] ^ sum[msb]);
                end
                cpuPkg::opSubs: begin
                    writeData = diff[msb:0];
                    flagsNext[3] = diff[msb];
                    flagsNext[2] = (diff[msb:0] == '0);
                    flagsNext[1] = !diff[msb+1]; // No borrow
                    flagsNext[0] = (readDataFirst[msb] ^ operandB[msb]) &&
                                   (readDataFirst[msb] ^ diff[msb]);
                end
                cpuPkg::opAnds: begin
                    writeData = andResult;
                    flagsNext[3] = andResult[msb]; // C and V kept
                    flagsNext[2] = (andResult == '0);
                end
                default: writeToReg = 1'b0;
            endcase
        end
    end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic clk,
    input  logic rst,
    input  logic [cpuPkg::regAddrWidth-1:0] readRegDest,
    input  logic [cpuPkg::regAddrWidth-1:0] readRegFirst,
    input  logic [cpuPkg::regAddrWidth-1:0] readRegSec,
    input  logic writeToReg,
    input  logic [cpuPkg::dataWidth-1:0] writeData,
    output logic [cpuPkg::dataWidth-1:0] readDataDest,
    output logic [cpuPkg::dataWidth-1:0] readDataFirst,
    output logic [cpuPkg::dataWidth-1:0] readDataSec
);

    localparam int numRegs = 2 ** cpuPkg::regAddrWidth;

    logic [cpuPkg::dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeToReg) begin
            regs[readRegDest] <= writeData; // Destination doubles as write address
        end
    end

    // Three combinational read ports
    assign readDataDest = regs[readRegDest];
    assign readDataFirst = regs[readRegFirst];
    assign readDataSec = regs[readRegSec];

endmodule

//--- logic/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
    parameter int dataDepth = 64
) (
    input  logic clk,
    input  logic [cpuPkg::dataWidth-1:0] memoryAddressOut,
    input  logic [cpuPkg::dataWidth-1:0] memoryDataOut,
    input  logic memoryWrite,
    input  logic memoryRead,
    output logic [cpuPkg::dataWidth-1:0] memoryDataIn
);

    localparam int indexBits = $clog2(dataDepth);

    logic [cpuPkg::dataWidth-1:0] mem [dataDepth];
    logic [indexBits-1:0] wordIndex;

    // Addresses count words, upper bits wrap
    assign wordIndex = memoryAddressOut[indexBits-1:0];

    always_ff @(posedge clk) begin
        if (memoryWrite) begin
            mem[wordIndex] <= memoryDataOut;
        end
    end

    assign memoryDataIn = memoryRead ? mem[wordIndex] : '0;

endmodule

//--- logic/cpuCore.sv
`timescale 1ns/1ps

module cpuCore #(
    parameter int progDepth = 64,
    parameter int dataDepth = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic progWrite,
    input  logic [$clog2(progDepth)-1:0] progAddr,
    input  logic [cpuPkg::dataWidth-1:0] progData,
    output logic [cpuPkg::dataWidth-1:0] pc,
    output logic regWriteEn,
    output logic [cpuPkg::regAddrWidth-1:0] regWriteAddr,
    output logic [cpuPkg::dataWidth-1:0] regWriteData,
    output logic memWriteEn,
    output logic [cpuPkg::dataWidth-1:0] memWriteAddr,
    output logic [cpuPkg::dataWidth-1:0] memWriteData
);

    cpuPkg::instrWord instr;
    logic [1:0] firstLevelDecode;
    logic specialEncoding;
    logic [3:0] secondLevelDecode;
    logic [2:0] aluFunctions;
    logic [cpuPkg::regAddrWidth-1:0] destReg;
    logic [cpuPkg::regAddrWidth-1:0] sourceFirstReg;
    logic [cpuPkg::regAddrWidth-1:0] sourceSecReg;
    logic [cpuPkg::immWidth-1:0] imm;
    logic [cpuPkg::regAddrWidth-1:0] readRegFirst;
    logic [cpuPkg::regAddrWidth-1:0] readRegSec;
    logic [cpuPkg::dataWidth-1:0] readDataDest;
    logic [cpuPkg::dataWidth-1:0] readDataFirst;
    logic [cpuPkg::dataWidth-1:0] readDataSec;
    logic exeOverride;
    logic [cpuPkg::immWidth-1:0] exeData;
    logic memoryRead;
    logic [cpuPkg::dataWidth-1:0] memoryDataIn;

    fetchUnit #(.progDepth(progDepth)) fetch (
        .clk(clk),
        .rst(rst),
        .run(run),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .exeOverride(exeOverride),
        .exeData(exeData),
        .pc(pc),
        .instr(instr)
    );

    // Run tie keeps the halted word from writing
    instrDecoder decoder (
        .run(run),
        .instr(instr),
        .firstLevelDecode(firstLevelDecode),
        .specialEncoding(specialEncoding),
        .secondLevelDecode(secondLevelDecode),
        .aluFunctions(aluFunctions),
        .destReg(destReg),
        .sourceFirstReg(sourceFirstReg),
        .sourceSecReg(sourceSecReg),
        .imm(imm)
    );

    // Write strobes go straight to the trace taps
    execute exe (
        .clk(clk),
        .rst(rst),
        .firstLevelDecode(firstLevelDecode),
        .specialEncoding(specialEncoding),
        .secondLevelDecode(secondLevelDecode),
        .aluFunctions(aluFunctions),
        .imm(imm),
        .destReg(destReg),
        .sourceFirstReg(sourceFirstReg),
        .sourceSecReg(sourceSecReg),
        .readDataDest(readDataDest),
        .readDataFirst(readDataFirst),
        .readDataSec(readDataSec),
        .readRegDest(regWriteAddr),
        .readRegFirst(readRegFirst),
        .readRegSec(readRegSec),
        .writeData(regWriteData),
        .writeToReg(regWriteEn),
        .exeOverride(exeOverride),
        .exeData(exeData),
        .memoryDataOut(memWriteData),
        .memoryAddressOut(memWriteAddr),
        .memoryWrite(memWriteEn),
        .memoryRead(memoryRead),
        .memoryDataIn(memoryDataIn)
    );

    registerFile regFile (
        .clk(clk),
        .rst(rst),
        .readRegDest(regWriteAddr),
        .readRegFirst(readRegFirst),
        .readRegSec(readRegSec),
        .writeToReg(regWriteEn),
        .writeData(regWriteData),
        .readDataDest(readDataDest),
        .readDataFirst(readDataFirst),
        .readDataSec(readDataSec)
    );

    dataMemory #(.dataDepth(dataDepth)) dataMem (
        .clk(clk),
        .memoryAddressOut(memWriteAddr),
        .memoryDataOut(memWriteData),
        .memoryWrite(memWriteEn),
        .memoryRead(memoryRead),
        .memoryDataIn(memoryDataIn)
    );

endmodule

//--- verif/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;

    localparam int progDepth = 64;
    localparam int dataDepth = 64;
    localparam int clkPeriod = 8;
    localparam int fileSize = 256;
    localparam logic [31:0] kindReg = 32'h1;
    localparam logic [31:0] kindMem = 32'h2;

    logic clk;
    logic rst;
    logic run;
    logic progWrite;
    logic [$clog2(progDepth)-1:0] progAddr;
    logic [cpuPkg::dataWidth-1:0] progData;
    logic [cpuPkg::dataWidth-1:0] pc;
    logic regWriteEn;
    logic [cpuPkg::regAddrWidth-1:0] regWriteAddr;
    logic [cpuPkg::dataWidth-1:0] regWriteData;
    logic memWriteEn;
    logic [cpuPkg::dataWidth-1:0] memWriteAddr;
    logic [cpuPkg::dataWidth-1:0] memWriteData;

    logic [31:0] fileWords [fileSize]; // Length word, program, then trace triples
    int progLen;
    int traceBase;
    int traceLen;
    int traceIndex;
    bit limitReady;

    cpuCore #(.progDepth(progDepth), .dataDepth(dataDepth)) DUT (
        .clk(clk),
        .rst(rst),
        .run(run),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .pc(pc),
        .regWriteEn(regWriteEn),
        .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData),
        .memWriteEn(memWriteEn),
        .memWriteAddr(memWriteAddr),
        .memWriteData(memWriteData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic checkRegWrite(input logic [cpuPkg::regAddrWidth-1:0] expAddr,
                                 input logic [cpuPkg::dataWidth-1:0] expData);
        if (!regWriteEn) begin
            abortRun($sformatf("Trace entry %0d expected a register write, got a memory write",
                               traceIndex));
        end else if (regWriteAddr !== expAddr) begin
            abortRun($sformatf("Error: regWriteAddr expected 0x%h got 0x%h",
                               expAddr, regWriteAddr));
        end else if (regWriteData !== expData) begin
            abortRun($sformatf("Error: regWriteData expected 0x%h got 0x%h",
                               expData, regWriteData));
        end
    endtask

    task automatic checkMemWrite(input logic [cpuPkg::dataWidth-1:0] expAddr,
                                 input logic [cpuPkg::dataWidth-1:0] expData);
        if (!memWriteEn) begin
            abortRun($sformatf("Trace entry %0d expected a memory write, got a register write",
                               traceIndex));
        end else if (memWriteAddr !== expAddr) begin
            abortRun($sformatf("Error: memWriteAddr expected 0x%h got 0x%h",
                               expAddr, memWriteAddr));
        end else if (memWriteData !== expData) begin
            abortRun($sformatf("Error: memWriteData expected 0x%h got 0x%h",
                               expData, memWriteData));
        end
    endtask

    // Halted core keeps pc at zero and raises no strobe
    task automatic checkHalted();
        if (regWriteEn || memWriteEn) begin
            abortRun("A write strobe was raised while run was low");
        end else if (pc !== '0) begin
            abortRun($sformatf("Error: pc expected 0x%h got 0x%h", 32'h0, pc));
        end
    endtask

    task automatic consumeEntry();
        int base;
        logic [31:0] kind;
        if (traceIndex >= traceLen) begin
            abortRun("A write appeared after the expected trace had ended");
        end else begin
            base = traceBase + 3 * traceIndex;
            kind = fileWords[base];
            if (kind == kindReg) begin
                checkRegWrite(fileWords[base + 1][cpuPkg::regAddrWidth-1:0], fileWords[base + 2]);
            end else if (kind == kindMem) begin
                checkMemWrite(fileWords[base + 1], fileWords[base + 2]);
            end else begin
                abortRun($sformatf("Trace entry %0d has an unknown kind", traceIndex));
            end
            traceIndex++;
        end
    endtask

    // Mid-cycle sample shows what the next rising edge commits
    always @(negedge clk) begin
        #1;
        if (!rst && !run) begin
            checkHalted();
        end else if (run && (regWriteEn || memWriteEn)) begin
            consumeEntry();
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        run = 1'b0;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        traceIndex = 0;
        traceLen = 0;
        limitReady = 1'b0;
        $readmemh("verif/cpu_testdata.txt", fileWords);
        progLen = fileWords[0];
        traceBase = progLen + 1;
        if (progLen < 1 || progLen > progDepth) begin
            abortRun("The data file is missing or its program length is out of range");
        end
        // Kind zero closes the trace
        while (traceBase + 3 * traceLen < fileSize &&
               fileWords[traceBase + 3 * traceLen] != 0) begin
            traceLen++;
        end
        limitReady = 1'b1;

        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < progLen; i++) begin
            @(negedge clk);
            progWrite = 1'b1;
            progAddr = i[$clog2(progDepth)-1:0];
            progData = fileWords[i + 1];
        end
        @(negedge clk);
        progWrite = 1'b0;
        @(negedge clk);
        run = 1'b1;

        wait (traceIndex == traceLen);
        repeat (10) @(negedge clk); // Stray writes after the trace still get caught
        $display("Regression passed");
        $finish;
    end

    // Watchdog sized from the trace length and the load time
    initial begin
        int limitCycles;
        wait (limitReady);
        limitCycles = 20 * traceLen + progLen + 8 + 20;
        #(limitCycles * clkPeriod);
        abortRun($sformatf("Watchdog expired, the trace did not finish (%0d of %0d entries seen)",
                           traceIndex, traceLen));
    end

endmodule

//--- verif/cpu_testdata.txt
// Word 0 is the program length, then the program words, four per line.
// Trace entries follow as kind address value, kind 1 register write, 2 memory write, 0 end.
28
00210002 02202468 06400000 08640008 // MOV, MOVT, SET, LSL
0A840038 04400000 22A80020 24C80040 // LSR, CLR, ADD imm, SUB imm
26E301E0 430AC000 452AC000 536CA000 // AND imm, ADD reg, SUB reg, ADDS reg
0D400000 0988003E 35B80002 0D400000 // MOVF, LSL, SUBS imm, MOVF
33DA0002 0D400000 55E88000 0D400000 // ADDS imm, MOVF, SUBS reg, MOVF
37790000 0D400000 8329FFFC 804BFFDC // ANDS imm, MOVF, store, load
C8000004 0060175A C0000004 00600222 // BMI taken, skipped MOV, BEQ not taken, MOV
C2000004 0060175A 55E88000 C8000004 // BNE taken, skipped MOV, SUBS, BMI not taken
00600444 C2000004 00600666 C0000004 // MOV, BNE not taken, MOV, BEQ taken
0060175A 00800888 C0000000 C2000000 // skipped MOV, MOV, idle loop
1 1 FFFF8001  1 1 12348001          // MOV sign extension, MOVT keeps low half
1 2 FFFFFFFF  1 3 FFFFFFF0          // SET, LSL by 4
1 4 0000000F  1 2 00000000          // LSR by 28, CLR
1 5 0000001F  1 6 FFFFFFEF          // ADD and SUB immediate
1 7 12348000  1 8 0000000E          // AND immediate, ADD register
1 9 00000030  1 B 0000000E          // SUB register, ADDS with carry out
1 A 00000002  1 C 80000000          // NZCV 0010, LSL by 31
1 D 7FFFFFFF  1 A 00000003          // SUBS overflow, NZCV 0011
1 E 80000000  1 A 00000009          // ADDS overflow, NZCV 1001
1 F 00000000  1 A 00000006          // SUBS zero result, NZCV 0110
1 B 80000000  1 A 0000000A          // ANDS, NZCV 1010 with C and V kept
2 0000000D 00000030  1 2 00000030   // store at r4 minus 2, load back
1 3 00000111  1 F 00000000          // MOV after BEQ not taken, SUBS sets Z
1 3 00000222  1 3 00000333          // BMI and BNE not taken
1 4 00000444  0 0 0                 // landing after BEQ taken, end

//--- list.f
common/cpuPkg.sv
logic/fetchUnit.sv
logic/instrDecoder.sv
execute/execute.sv
logic/registerFile.sv
logic/dataMemory.sv
logic/cpuCore.sv
verif/cpuCoreTb.sv

//--- run.sh
#!/bin/sh
# Build the cpuCore testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module cpuCoreTb -f list.f -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Regression passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
